/* Makefile */
VERILATOR = verilator
VFLAGS    = --binary --assert -j 0
TOP       = kv_tb
FILELIST  = kv_top.f
OBJ_DIR   = obj_dir
LOG       = sim.log

BIN     = $(OBJ_DIR)/V$(TOP)
SOURCES = $(filter-out +%,$(shell cat $(FILELIST))) design/kv_defines.svh

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "TESTS FAILED" $(LOG); then exit 1; fi
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* design/kv_ctrl_regs.sv */
//**********************************************************************
// key vault control registers
// sticky locks, clear and flush pulses, debug select and readback
//**********************************************************************
`timescale 1ns/100ps
`default_nettype none

`include "kv_defines.svh"

module kv_ctrl_regs (
    input  logic                                      clk,
    input  logic                                      rst_n_i,
    input  logic                                      reg_access_i,
    input  kv_pkg::kv_sw_cmd_t                        reg_cmd_i,
    input  logic                                      fw_update_window_i,
    input  logic                                      debug_unlock_i,
    input  kv_pkg::kv_dest_t   [`KV_NUM_KEYS-1:0]     dest_valid_i,
    input  kv_pkg::kv_offset_t [`KV_NUM_KEYS-1:0]     last_dword_i,
    output kv_pkg::kv_dword_t                         reg_rdata_o,
    output logic                                      reg_err_o,
    output logic [`KV_NUM_KEYS-1:0]                   wr_blocked_o,
    output logic [`KV_NUM_KEYS-1:0]                   use_locked_o,
    output logic [`KV_NUM_KEYS-1:0]                   clear_o,
    output logic [`KV_NUM_KEYS-1:0]                   flush_o,
    output kv_pkg::kv_dword_t                         debug_value_o
);

    logic [`KV_NUM_KEYS-1:0] lock_wr_q;
    logic [`KV_NUM_KEYS-1:0] lock_use_q;
    logic [`KV_NUM_KEYS-1:0] clear_q;
    logic                    wr_debug_q;
    logic                    sel_debug_q;
    logic                    hit_ctrl;
    logic                    hit_clr;
    logic                    do_write;
    kv_pkg::kv_entry_t       entry;

    // address decode
    assign hit_ctrl  = (reg_cmd_i.addr < `KV_NUM_KEYS);
    assign hit_clr   = (reg_cmd_i.addr == `KV_CLEAR_SECRETS_ADDR);
    assign entry     = reg_cmd_i.addr[$bits(kv_pkg::kv_entry_t)-1:0];
    assign do_write  = reg_access_i & reg_cmd_i.write;
    assign reg_err_o = ~(hit_ctrl | hit_clr);

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            lock_wr_q   <= '0;
            lock_use_q  <= '0;
            clear_q     <= '0;
            wr_debug_q  <= 1'b0;
            sel_debug_q <= 1'b0;
        end else begin
            clear_q    <= '0;
            wr_debug_q <= 1'b0;
            if (do_write && hit_ctrl) begin
                // locks only ever set, reset is the way out
                lock_wr_q[entry]  <= lock_wr_q[entry] | reg_cmd_i.wdata[0];
                lock_use_q[entry] <= lock_use_q[entry] | reg_cmd_i.wdata[1];
                clear_q[entry]    <= reg_cmd_i.wdata[2];
            end
            if (do_write && hit_clr) begin
                wr_debug_q  <= reg_cmd_i.wdata[0];
                sel_debug_q <= reg_cmd_i.wdata[1];
            end
        end
    end

    // update window masks every lock
    assign use_locked_o = lock_use_q & {`KV_NUM_KEYS{~fw_update_window_i}};
    assign wr_blocked_o = (lock_wr_q | lock_use_q) & {`KV_NUM_KEYS{~fw_update_window_i}};

    assign clear_o = clear_q & ~wr_blocked_o;
    // debug unlock wipes everything, locked or not
    assign flush_o = ({`KV_NUM_KEYS{wr_debug_q}} & ~wr_blocked_o)
                   | {`KV_NUM_KEYS{debug_unlock_i}};
    assign debug_value_o = sel_debug_q ? `KV_DEBUG_VAL_1 : `KV_DEBUG_VAL_0;

    // readback, clear bit always reads as 0
    always_comb begin
        reg_rdata_o = '0;
        if (hit_ctrl) begin
            reg_rdata_o[0]     = lock_wr_q[entry];
            reg_rdata_o[1]     = lock_use_q[entry];
            reg_rdata_o[9:8]   = dest_valid_i[entry];
            reg_rdata_o[18:16] = last_dword_i[entry];
        end else if (hit_clr) begin
            reg_rdata_o[1] = sel_debug_q;
        end
    end

    locks_sticky: assert property (@(posedge clk) disable iff (!rst_n_i)
        $past(rst_n_i) |-> (((lock_wr_q & $past(lock_wr_q)) == $past(lock_wr_q))
                         && ((lock_use_q & $past(lock_use_q)) == $past(lock_use_q))));

endmodule

`default_nettype wire

/* design/kv_defines.svh */
//**********************************************************************
// key vault defines
// sizes, register map and debug flush patterns for the key vault
//**********************************************************************
`ifndef KV_DEFINES_SVH
`define KV_DEFINES_SVH

// vault geometry
`define KV_NUM_KEYS       8
`define KV_NUM_DWORDS     8
`define KV_NUM_WRITE      2
`define KV_NUM_READ       2
`define KV_SIGNING_ENTRY  7

// register map, word addresses
`define KV_REG_ADDR_W          5
`define KV_CLEAR_SECRETS_ADDR  16

// flush patterns
`define KV_DEBUG_VAL_0  32'hAAAA_AAAA
`define KV_DEBUG_VAL_1  32'h5555_5555

`endif

/* design/kv_key_store.sv */
//**********************************************************************
// key vault storage
// key dwords, dest-valid and last-dword per entry, client write mux
//**********************************************************************
`timescale 1ns/100ps
`default_nettype none

`include "kv_defines.svh"

module kv_key_store (
    input  logic                                                      clk,
    input  logic                                                      rst_n_i,
    input  kv_pkg::kv_write_t   [`KV_NUM_WRITE-1:0]                   kv_write_i,
    input  logic                [`KV_NUM_KEYS-1:0]                    wr_blocked_i,
    input  logic                [`KV_NUM_KEYS-1:0]                    clear_i,
    input  logic                [`KV_NUM_KEYS-1:0]                    flush_i,
    input  kv_pkg::kv_dword_t                                         debug_value_i,
    output kv_pkg::kv_wr_resp_t [`KV_NUM_WRITE-1:0]                   kv_wr_resp_o,
    output kv_pkg::kv_dword_t   [`KV_NUM_KEYS-1:0][`KV_NUM_DWORDS-1:0] key_data_o,
    output kv_pkg::kv_dest_t    [`KV_NUM_KEYS-1:0]                    dest_valid_o,
    output kv_pkg::kv_offset_t  [`KV_NUM_KEYS-1:0]                    last_dword_o,
    output kv_pkg::kv_dword_t   [`KV_NUM_DWORDS-1:0]                  signing_key_o
);

    kv_pkg::kv_dword_t  [`KV_NUM_KEYS-1:0][`KV_NUM_DWORDS-1:0] key_q;
    kv_pkg::kv_dword_t  [`KV_NUM_KEYS-1:0][`KV_NUM_DWORDS-1:0] key_d;
    kv_pkg::kv_dest_t   [`KV_NUM_KEYS-1:0]                     dest_q;
    kv_pkg::kv_dest_t   [`KV_NUM_KEYS-1:0]                     dest_d;
    kv_pkg::kv_offset_t [`KV_NUM_KEYS-1:0]                     last_q;
    kv_pkg::kv_offset_t [`KV_NUM_KEYS-1:0]                     last_d;
    logic               [`KV_NUM_KEYS-1:0][`KV_NUM_WRITE-1:0]  hit;

    // next state: flush, then clear, then the AND-OR client writes
    always_comb begin
        key_d  = key_q;
        dest_d = dest_q;
        last_d = last_q;
        for (int e = 0; e < `KV_NUM_KEYS; e++) begin
            if (flush_i[e]) begin
                for (int d = 0; d < `KV_NUM_DWORDS; d++) begin
                    key_d[e][d] = debug_value_i;
                end
            end
            if (clear_i[e]) begin
                key_d[e]  = '0;
                dest_d[e] = '0;
                last_d[e] = '0;
            end
            for (int c = 0; c < `KV_NUM_WRITE; c++) begin
                hit[e][c] = kv_write_i[c].write_en & (kv_write_i[c].write_entry == e)
                          & ~wr_blocked_i[e];
            end
            if (|hit[e]) begin
                dest_d[e] = '0;
                last_d[e] = '0;
                for (int c = 0; c < `KV_NUM_WRITE; c++) begin
                    dest_d[e] |= hit[e][c] ? kv_write_i[c].write_dest_valid : '0;
                    last_d[e] |= hit[e][c] ? kv_write_i[c].write_offset : '0;
                end
            end
            for (int d = 0; d < `KV_NUM_DWORDS; d++) begin
                if (|(hit[e] & dword_sel(d))) begin
                    key_d[e][d] = '0;
                    for (int c = 0; c < `KV_NUM_WRITE; c++) begin
                        key_d[e][d] |= (hit[e][c] && kv_write_i[c].write_offset == d)
                                     ? kv_write_i[c].write_data : '0;
                    end
                end
            end
        end
    end

    // clients whose offset points at dword d
    function automatic logic [`KV_NUM_WRITE-1:0] dword_sel(input int d);
        logic [`KV_NUM_WRITE-1:0] sel;
        for (int c = 0; c < `KV_NUM_WRITE; c++) begin
            sel[c] = (kv_write_i[c].write_offset == d);
        end
        return sel;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            key_q  <= '0;
            dest_q <= '0;
            last_q <= '0;
        end else begin
            key_q  <= key_d;
            dest_q <= dest_d;
            last_q <= last_d;
        end
    end

    always_comb begin
        for (int c = 0; c < `KV_NUM_WRITE; c++) begin
            kv_wr_resp_o[c].error = kv_write_i[c].write_en
                                  & wr_blocked_i[kv_write_i[c].write_entry];
        end
    end

    assign key_data_o    = key_q;
    assign dest_valid_o  = dest_q;
    assign last_dword_o  = last_q;
    assign signing_key_o = key_q[`KV_SIGNING_ENTRY];

    for (genvar e = 0; e < `KV_NUM_KEYS; e++) begin : g_blocked_chk
        blocked_entry_stable: assert property (@(posedge clk) disable iff (!rst_n_i)
            $past(rst_n_i) && $past(wr_blocked_i[e]) && !$past(flush_i[e])
            |-> key_q[e] == $past(key_q[e]));
    end

endmodule

`default_nettype wire

/* design/kv_pkg.sv */
//**********************************************************************
// key vault package
// width types, client structs, register command and port FSM states
//**********************************************************************
`default_nettype none

`include "kv_defines.svh"

package kv_pkg;

    typedef logic [$clog2(`KV_NUM_KEYS)-1:0]   kv_entry_t;
    typedef logic [$clog2(`KV_NUM_DWORDS)-1:0] kv_offset_t;
    typedef logic [31:0]                       kv_dword_t;
    typedef logic [`KV_NUM_READ-1:0]           kv_dest_t;
    typedef logic [`KV_REG_ADDR_W-1:0]         kv_reg_addr_t;

    // crypto client write request
    typedef struct packed {
        logic       write_en;
        kv_entry_t  write_entry;
        kv_offset_t write_offset;
        kv_dword_t  write_data;
        kv_dest_t   write_dest_valid;
    } kv_write_t;

    typedef struct packed {
        kv_entry_t  read_entry;
        kv_offset_t read_offset;
    } kv_read_t;

    typedef struct packed {
        kv_dword_t read_data;
        logic      error;
        logic      last;
    } kv_rd_resp_t;

    typedef struct packed {
        logic error;
    } kv_wr_resp_t;

    // firmware register command
    typedef struct packed {
        logic         write;
        kv_reg_addr_t addr;
        kv_dword_t    wdata;
    } kv_sw_cmd_t;

    typedef enum logic [1:0] {
        SW_IDLE,
        SW_ACCESS,
        SW_ACK,
        SW_DROP
    } kv_sw_state_e;

endpackage

`default_nettype wire

/* design/kv_read_port.sv */
//**********************************************************************
// key vault read port
// per-client permission checked read mux with error and last flags
//**********************************************************************
`timescale 1ns/100ps
`default_nettype none

`include "kv_defines.svh"

module kv_read_port (
    input  kv_pkg::kv_read_t    [`KV_NUM_READ-1:0]                    kv_read_i,
    input  kv_pkg::kv_dword_t   [`KV_NUM_KEYS-1:0][`KV_NUM_DWORDS-1:0] key_data_i,
    input  kv_pkg::kv_dest_t    [`KV_NUM_KEYS-1:0]                    dest_valid_i,
    input  kv_pkg::kv_offset_t  [`KV_NUM_KEYS-1:0]                    last_dword_i,
    input  logic                [`KV_NUM_KEYS-1:0]                    use_locked_i,
    output kv_pkg::kv_rd_resp_t [`KV_NUM_READ-1:0]                    kv_rd_resp_o
);

    always_comb begin
        for (int c = 0; c < `KV_NUM_READ; c++) begin
            kv_rd_resp_o[c] = '0;
            for (int e = 0; e < `KV_NUM_KEYS; e++) begin
                if (kv_read_i[c].read_entry == e) begin
                    // no data without permission or while the entry is use-locked
                    kv_rd_resp_o[c].error = use_locked_i[e] | ~dest_valid_i[e][c];
                    if (!kv_rd_resp_o[c].error) begin
                        kv_rd_resp_o[c].read_data = key_data_i[e][kv_read_i[c].read_offset];
                    end
                    kv_rd_resp_o[c].last = (kv_read_i[c].read_offset == last_dword_i[e]);
                end
            end
            no_data_on_error: assert (!kv_rd_resp_o[c].error
                                      || kv_rd_resp_o[c].read_data == '0);
        end
    end

endmodule

`default_nettype wire

/* design/kv_sw_port.sv */
//**********************************************************************
// key vault firmware port
// four-phase req/ack slave, one register access per handshake
//**********************************************************************
`timescale 1ns/100ps
`default_nettype none

module kv_sw_port (
    input  logic               clk,
    input  logic               rst_n_i,
    input  logic               sw_req_i,
    input  kv_pkg::kv_sw_cmd_t sw_cmd_i,
    input  kv_pkg::kv_dword_t  reg_rdata_i,
    input  logic               reg_err_i,
    output logic               sw_ack_o,
    output kv_pkg::kv_dword_t  sw_rdata_o,
    output logic               sw_err_o,
    output logic               reg_access_o,
    output kv_pkg::kv_sw_cmd_t reg_cmd_o
);

    kv_pkg::kv_sw_state_e state_q;
    kv_pkg::kv_sw_state_e state_d;

    always_comb begin
        state_d = state_q;
        case (state_q)
            kv_pkg::SW_IDLE: begin
                if (sw_req_i) begin
                    state_d = kv_pkg::SW_ACCESS;
                end
            end
            kv_pkg::SW_ACCESS: state_d = kv_pkg::SW_ACK;
            kv_pkg::SW_ACK: begin
                // hold ack until the master lets go of req
                if (!sw_req_i) begin
                    state_d = kv_pkg::SW_DROP;
                end
            end
            default: state_d = kv_pkg::SW_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rst_n_i) begin
            state_q <= kv_pkg::SW_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // command latched on accept, response latched at the end of the access
    always_ff @(posedge clk) begin
        if (state_q == kv_pkg::SW_IDLE && sw_req_i) begin
            reg_cmd_o <= sw_cmd_i;
        end
        if (state_q == kv_pkg::SW_ACCESS) begin
            sw_rdata_o <= reg_rdata_i;
            sw_err_o   <= reg_err_i;
        end
    end

    assign reg_access_o = (state_q == kv_pkg::SW_ACCESS);
    assign sw_ack_o     = (state_q == kv_pkg::SW_ACK);

    ack_follows_req: assert property (@(posedge clk) disable iff (!rst_n_i)
        $rose(sw_ack_o) |-> sw_req_i);

    access_single_pulse: assert property (@(posedge clk) disable iff (!rst_n_i)
        reg_access_o |=> !reg_access_o);

endmodule

`default_nettype wire

/* design/kv_top.sv */
//**********************************************************************
// key vault top
// firmware port, control registers, key storage and client read mux
//**********************************************************************
`timescale 1ns/100ps
`default_nettype none

`include "kv_defines.svh"

module kv_top (
    input  logic                                     clk,
    input  logic                                     rst_n_i,
    input  logic                                     fw_update_window_i,
    input  logic                                     debug_unlock_i,
    input  logic                                     sw_req_i,
    input  kv_pkg::kv_sw_cmd_t                       sw_cmd_i,
    input  kv_pkg::kv_write_t   [`KV_NUM_WRITE-1:0]  kv_write_i,
    input  kv_pkg::kv_read_t    [`KV_NUM_READ-1:0]   kv_read_i,
    output logic                                     sw_ack_o,
    output kv_pkg::kv_dword_t                        sw_rdata_o,
    output logic                                     sw_err_o,
    output kv_pkg::kv_wr_resp_t [`KV_NUM_WRITE-1:0]  kv_wr_resp_o,
    output kv_pkg::kv_rd_resp_t [`KV_NUM_READ-1:0]   kv_rd_resp_o,
    output kv_pkg::kv_dword_t   [`KV_NUM_DWORDS-1:0] signing_key_o
);

    logic                                                  reg_access;
    kv_pkg::kv_sw_cmd_t                                    reg_cmd;
    kv_pkg::kv_dword_t                                     reg_rdata;
    logic                                                  reg_err;
    logic               [`KV_NUM_KEYS-1:0]                 wr_blocked;
    logic               [`KV_NUM_KEYS-1:0]                 use_locked;
    logic               [`KV_NUM_KEYS-1:0]                 clear;
    logic               [`KV_NUM_KEYS-1:0]                 flush;
    kv_pkg::kv_dword_t                                     debug_value;
    kv_pkg::kv_dword_t  [`KV_NUM_KEYS-1:0][`KV_NUM_DWORDS-1:0] key_data;
    kv_pkg::kv_dest_t   [`KV_NUM_KEYS-1:0]                 dest_valid;
    kv_pkg::kv_offset_t [`KV_NUM_KEYS-1:0]                 last_dword;

    kv_sw_port sw_port_i (
        .clk          (clk),
        .rst_n_i      (rst_n_i),
        .sw_req_i     (sw_req_i),
        .sw_cmd_i     (sw_cmd_i),
        .reg_rdata_i  (reg_rdata),
        .reg_err_i    (reg_err),
        .sw_ack_o     (sw_ack_o),
        .sw_rdata_o   (sw_rdata_o),
        .sw_err_o     (sw_err_o),
        .reg_access_o (reg_access),
        .reg_cmd_o    (reg_cmd)
    );

    kv_ctrl_regs ctrl_regs_i (
        .clk                (clk),
        .rst_n_i            (rst_n_i),
        .reg_access_i       (reg_access),
        .reg_cmd_i          (reg_cmd),
        .fw_update_window_i (fw_update_window_i),
        .debug_unlock_i     (debug_unlock_i),
        .dest_valid_i       (dest_valid),
        .last_dword_i       (last_dword),
        .reg_rdata_o        (reg_rdata),
        .reg_err_o          (reg_err),
        .wr_blocked_o       (wr_blocked),
        .use_locked_o       (use_locked),
        .clear_o            (clear),
        .flush_o            (flush),
        .debug_value_o      (debug_value)
    );

    kv_key_store key_store_i (
        .clk           (clk),
        .rst_n_i       (rst_n_i),
        .kv_write_i    (kv_write_i),
        .wr_blocked_i  (wr_blocked),
        .clear_i       (clear),
        .flush_i       (flush),
        .debug_value_i (debug_value),
        .kv_wr_resp_o  (kv_wr_resp_o),
        .key_data_o    (key_data),
        .dest_valid_o  (dest_valid),
        .last_dword_o  (last_dword),
        .signing_key_o (signing_key_o)
    );

    kv_read_port read_port_i (
        .kv_read_i    (kv_read_i),
        .key_data_i   (key_data),
        .dest_valid_i (dest_valid),
        .last_dword_i (last_dword),
        .use_locked_i (use_locked),
        .kv_rd_resp_o (kv_rd_resp_o)
    );

endmodule

`default_nettype wire

/* kv_top.f */
+incdir+design
design/kv_pkg.sv
design/kv_sw_port.sv
design/kv_ctrl_regs.sv
design/kv_key_store.sv
design/kv_read_port.sv
design/kv_top.sv
verif/kv_tb.sv

/* verif/kv_tb.sv */
//**********************************************************************
// key vault testbench
// directed tests of the firmware port, client writes and reads,
// locks, clear, flush and debug unlock against a reference model
//**********************************************************************
`timescale 1ns/100ps
`default_nettype none

`include "kv_defines.svh"

module kv_tb;

    // about 700 cycles of traffic in total, the limit leaves ample margin
    localparam int TIMEOUT_CYCLES = 4000;
    localparam int ACK_WAIT_LIMIT = 20;

    logic                                            clk;
    logic                                            rst_n;
    logic                                            fw_update_window;
    logic                                            debug_unlock;
    logic                                            sw_req;
    kv_pkg::kv_sw_cmd_t                              sw_cmd;
    kv_pkg::kv_write_t   [`KV_NUM_WRITE-1:0]         kv_write;
    kv_pkg::kv_read_t    [`KV_NUM_READ-1:0]          kv_read;
    logic                                            sw_ack;
    kv_pkg::kv_dword_t                               sw_rdata;
    logic                                            sw_err;
    kv_pkg::kv_wr_resp_t [`KV_NUM_WRITE-1:0]         kv_wr_resp;
    kv_pkg::kv_rd_resp_t [`KV_NUM_READ-1:0]          kv_rd_resp;
    kv_pkg::kv_dword_t   [`KV_NUM_DWORDS-1:0]        signing_key;

    // reference model of the vault contents and lock state
    kv_pkg::kv_dword_t  exp_data [`KV_NUM_KEYS][`KV_NUM_DWORDS];
    kv_pkg::kv_dest_t   exp_dest [`KV_NUM_KEYS];
    kv_pkg::kv_offset_t exp_last [`KV_NUM_KEYS];
    logic [`KV_NUM_KEYS-1:0] lock_wr_m;
    logic [`KV_NUM_KEYS-1:0] lock_use_m;
    logic                    window_m;
    logic [31:0]             lfsr_q;
    int                      cycles;
    int                      checks;
    int                      errors;

    kv_top kv_top_i (
        .clk                (clk),
        .rst_n_i            (rst_n),
        .fw_update_window_i (fw_update_window),
        .debug_unlock_i     (debug_unlock),
        .sw_req_i           (sw_req),
        .sw_cmd_i           (sw_cmd),
        .kv_write_i         (kv_write),
        .kv_read_i          (kv_read),
        .sw_ack_o           (sw_ack),
        .sw_rdata_o         (sw_rdata),
        .sw_err_o           (sw_err),
        .kv_wr_resp_o       (kv_wr_resp),
        .kv_rd_resp_o       (kv_rd_resp),
        .signing_key_o      (signing_key)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= TIMEOUT_CYCLES) begin
            $display("timeout: the tests did not complete within %0d cycles", TIMEOUT_CYCLES);
            $display("TESTS FAILED");
            $finish;
        end
    end

    // x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_dword(output kv_pkg::kv_dword_t w);
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsr_q = lfsr_next(lfsr_q);
            w = {w[30:0], lfsr_q[0]};
        end
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        checks++;
        if (got !== exp) begin
            errors++;
            $display("ERROR at %0t: %s got %h expected %h", $time, name, got, exp);
        end
    endtask

    function automatic logic blocked(input int e);
        return (lock_wr_m[e] | lock_use_m[e]) & ~window_m;
    endfunction

    function automatic logic [31:0] ctrl_expect(input int e);
        logic [31:0] v;
        v = '0;
        v[0]     = lock_wr_m[e];
        v[1]     = lock_use_m[e];
        v[9:8]   = exp_dest[e];
        v[18:16] = exp_last[e];
        return v;
    endfunction

    // four-phase handshake, req held until ack, then released
    task automatic sw_access(input logic wr, input int addr, input kv_pkg::kv_dword_t wdata,
                             output kv_pkg::kv_dword_t rdata, output logic err);
        kv_pkg::kv_sw_cmd_t cmd;
        int                 waited;
        cmd.write = wr;
        cmd.addr  = 5'(addr);
        cmd.wdata = wdata;
        waited    = 0;
        @(posedge clk);
        sw_cmd <= cmd;
        sw_req <= 1'b1;
        @(negedge clk);
        while (!sw_ack && waited < ACK_WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!sw_ack) begin
            errors++;
            $display("sw_access: no ack for address %0d within %0d cycles", addr, waited);
        end
        rdata = sw_rdata;
        err   = sw_err;
        @(posedge clk);
        sw_req <= 1'b0;
        waited = 0;
        @(negedge clk);
        while (sw_ack && waited < ACK_WAIT_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (sw_ack) begin
            errors++;
            $display("sw_access: ack stayed high after req was dropped");
        end
    endtask

    task automatic reg_write(input int addr, input kv_pkg::kv_dword_t data, input logic exp_err);
        kv_pkg::kv_dword_t rdata;
        logic              err;
        sw_access(1'b1, addr, data, rdata, err);
        check("sw_err_o", 32'(err), 32'(exp_err));
    endtask

    task automatic reg_check(input int addr, input logic [31:0] exp, input logic exp_err);
        kv_pkg::kv_dword_t rdata;
        logic              err;
        sw_access(1'b0, addr, '0, rdata, err);
        check("sw_rdata_o", rdata, exp);
        check("sw_err_o", 32'(err), 32'(exp_err));
    endtask

    task automatic client_write(input int c, input int e, input int off,
                                input kv_pkg::kv_dword_t data, input kv_pkg::kv_dest_t dest);
        kv_pkg::kv_write_t w;
        logic              exp_err;
        w.write_en         = 1'b1;
        w.write_entry      = 3'(e);
        w.write_offset     = 3'(off);
        w.write_data       = data;
        w.write_dest_valid = dest;
        exp_err            = blocked(e);
        @(posedge clk);
        kv_write[c] <= w;
        @(negedge clk);
        check("kv_wr_resp_o.error", 32'(kv_wr_resp[c].error), 32'(exp_err));
        @(posedge clk);
        kv_write[c] <= '0;
        if (!exp_err) begin
            exp_data[e][off] = data;
            exp_dest[e]      = dest;
            exp_last[e]      = 3'(off);
        end
    endtask

    task automatic fill_entry(input int c, input int e, input int n, input kv_pkg::kv_dest_t dest);
        kv_pkg::kv_dword_t data;
        for (int d = 0; d < n; d++) begin
            rand_dword(data);
            client_write(c, e, d, data, dest);
        end
    endtask

    task automatic check_read(input int c, input int e, input int off);
        kv_pkg::kv_read_t  rd;
        logic              exp_err;
        kv_pkg::kv_dword_t exp_dat;
        rd.read_entry  = 3'(e);
        rd.read_offset = 3'(off);
        exp_err = (lock_use_m[e] & ~window_m) | ~exp_dest[e][c];
        exp_dat = exp_err ? '0 : exp_data[e][off];
        @(posedge clk);
        kv_read[c] <= rd;
        @(negedge clk);
        check("kv_rd_resp_o.error", 32'(kv_rd_resp[c].error), 32'(exp_err));
        check("kv_rd_resp_o.read_data", kv_rd_resp[c].read_data, exp_dat);
        check("kv_rd_resp_o.last", 32'(kv_rd_resp[c].last), 32'(3'(off) == exp_last[e]));
    endtask

    task automatic check_all_reads();
        for (int c = 0; c < `KV_NUM_READ; c++) begin
            for (int e = 0; e < `KV_NUM_KEYS; e++) begin
                for (int d = 0; d < `KV_NUM_DWORDS; d++) begin
                    check_read(c, e, d);
                end
            end
        end
    endtask

    task automatic check_signing();
        @(negedge clk);
        for (int d = 0; d < `KV_NUM_DWORDS; d++) begin
            check("signing_key_o", signing_key[d], exp_data[`KV_SIGNING_ENTRY][d]);
        end
    endtask

    // flush model, only entries that are not write-blocked take the pattern
    task automatic apply_flush(input kv_pkg::kv_dword_t pattern, input logic force_all);
        for (int e = 0; e < `KV_NUM_KEYS; e++) begin
            if (force_all || !blocked(e)) begin
                for (int d = 0; d < `KV_NUM_DWORDS; d++) begin
                    exp_data[e][d] = pattern;
                end
            end
        end
    endtask

    task automatic test_done(input string name);
        $display("%s finished, %0d errors so far", name, errors);
    endtask

    task automatic reset_state();
        for (int e = 0; e < `KV_NUM_KEYS; e++) begin
            reg_check(e, 32'h0, 1'b0);
        end
        for (int c = 0; c < `KV_NUM_READ; c++) begin
            for (int e = 0; e < `KV_NUM_KEYS; e++) begin
                check_read(c, e, 0);
            end
        end
        check_signing();
        test_done("reset_state");
    endtask

    task automatic write_read();
        fill_entry(0, 3, 6, 2'b01);
        for (int d = 0; d < `KV_NUM_DWORDS; d++) begin
            check_read(0, 3, d);
            check_read(1, 3, d);
        end
        reg_check(3, ctrl_expect(3), 1'b0);
        // extra entries used by the lock, clear and flush tests
        fill_entry(1, 1, 3, 2'b10);
        fill_entry(0, 4, 2, 2'b11);
        fill_entry(1, `KV_SIGNING_ENTRY, `KV_NUM_DWORDS, 2'b11);
        check_signing();
        test_done("write_read");
    endtask

    task automatic lock_rules();
        kv_pkg::kv_dword_t data;
        reg_write(3, 32'h1, 1'b0);
        lock_wr_m[3] = 1'b1;
        rand_dword(data);
        client_write(0, 3, 2, data, 2'b01);
        check_read(0, 3, 2);
        reg_write(4, 32'h2, 1'b0);
        lock_use_m[4] = 1'b1;
        check_read(0, 4, 0);
        check_read(1, 4, 1);
        reg_write(3, 32'h0, 1'b0);
        reg_write(4, 32'h0, 1'b0);
        reg_check(3, ctrl_expect(3), 1'b0);
        reg_check(4, ctrl_expect(4), 1'b0);
        @(posedge clk);
        fw_update_window <= 1'b1;
        window_m = 1'b1;
        rand_dword(data);
        client_write(0, 3, 2, data, 2'b01);
        check_read(0, 3, 2);
        check_read(0, 4, 0);
        @(posedge clk);
        fw_update_window <= 1'b0;
        window_m = 1'b0;
        check_read(0, 3, 2);
        test_done("lock_rules");
    endtask

    task automatic entry_clear();
        reg_write(1, 32'h4, 1'b0);
        exp_data[1] = '{default: '0};
        exp_dest[1] = '0;
        exp_last[1] = '0;
        check_read(0, 1, 0);
        check_read(1, 1, 0);
        reg_check(1, ctrl_expect(1), 1'b0);
        // entry 3 is write-locked, the clear is ignored
        reg_write(3, 32'h4, 1'b0);
        for (int d = 0; d < `KV_NUM_DWORDS; d++) begin
            check_read(0, 3, d);
        end
        reg_check(3, ctrl_expect(3), 1'b0);
        test_done("entry_clear");
    endtask

    task automatic secret_flush();
        reg_write(`KV_CLEAR_SECRETS_ADDR, 32'h3, 1'b0);
        apply_flush(`KV_DEBUG_VAL_1, 1'b0);
        reg_check(`KV_CLEAR_SECRETS_ADDR, 32'h2, 1'b0);
        check_all_reads();
        check_signing();
        @(posedge clk);
        debug_unlock <= 1'b1;
        @(posedge clk);
        debug_unlock <= 1'b0;
        apply_flush(`KV_DEBUG_VAL_1, 1'b1);
        check_all_reads();
        check_signing();
        test_done("secret_flush");
    endtask

    task automatic bad_address();
        reg_check(20, 32'h0, 1'b1);
        reg_write(20, 32'hffff_ffff, 1'b1);
        for (int e = 0; e < `KV_NUM_KEYS; e++) begin
            reg_check(e, ctrl_expect(e), 1'b0);
        end
        reg_check(`KV_CLEAR_SECRETS_ADDR, 32'h2, 1'b0);
        test_done("bad_address");
    endtask

    initial begin
        rst_n            = 1'b0;
        fw_update_window = 1'b0;
        debug_unlock     = 1'b0;
        sw_req           = 1'b0;
        sw_cmd           = '0;
        kv_write         = '0;
        kv_read          = '0;
        window_m         = 1'b0;
        lock_wr_m        = '0;
        lock_use_m       = '0;
        lfsr_q           = 32'h4929771e;
        cycles           = 0;
        checks           = 0;
        errors           = 0;
        for (int e = 0; e < `KV_NUM_KEYS; e++) begin
            exp_data[e] = '{default: '0};
            exp_dest[e] = '0;
            exp_last[e] = '0;
        end
        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        reset_state();
        write_read();
        lock_rules();
        entry_clear();
        secret_flush();
        bad_address();
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
